/* common/layer_save_pkg.sv */
package layer_save_pkg;

    parameter int pix_w     = 8;
    parameter int num_ch    = 4;
    parameter int lanes     = 5;              // rows packed per buffer word
    parameter int word_w    = pix_w * lanes;

    parameter int b0_addr_w = 5;              // 32 words
    parameter int b1_addr_w = 4;              // 16 words

    parameter int width_w   = 4;
    parameter int min_width = 2;
    parameter int max_width = 12;             // 2*w-1 must fit block 0

    typedef logic signed [pix_w-1:0] pix_t;

    // one activated value per output channel
    typedef struct packed {
        pix_t [num_ch-1:0] ch;
    } pix_group_t;

    typedef struct packed {
        logic                 blk;            // 0: block 0, 1: block 1
        logic [b0_addr_w-1:0] addr;
        logic [lanes-1:0]     lane_en;        // one-hot byte lane
    } wr_pos_t;

    typedef struct packed {
        logic [num_ch-1:0][word_w-1:0] ch;
    } rd_word_t;

    typedef enum logic [1:0] {
        st_idle,
        st_saving,
        st_done
    } save_state_e;

endpackage

/* compile.f */
common/layer_save_pkg.sv
save_ctrl/save_fsm.sv
save_ctrl/raster_counter.sv
feature_buffer/feature_bank.sv
feature_buffer/feature_read_mux.sv
source/layer_result_saver.sv
tests/tb_layer_result_saver.sv

/* feature_buffer/feature_bank.sv */
module feature_bank #(
    parameter int pix_w     = layer_save_pkg::pix_w,
    parameter int lanes     = layer_save_pkg::lanes,
    parameter int b0_addr_w = layer_save_pkg::b0_addr_w,
    parameter int b1_addr_w = layer_save_pkg::b1_addr_w
) (
    input  logic                     clk,
    input  logic                     we,
    input  layer_save_pkg::wr_pos_t  wr_pos,
    input  logic signed [pix_w-1:0]  din,
    input  logic                     rd_en,
    input  logic                     rd_block,
    input  logic [b0_addr_w-1:0]     rd_addr,
    output logic [pix_w*lanes-1:0]   dout0,
    output logic [pix_w*lanes-1:0]   dout1
);

    logic [pix_w*lanes-1:0] mem0 [2**b0_addr_w];
    logic [pix_w*lanes-1:0] mem1 [2**b1_addr_w];

    // byte-lane write into the selected block
    always_ff @(posedge clk) begin
        for (int l = 0; l < lanes; l++) begin
            if (we && wr_pos.lane_en[l]) begin
                if (wr_pos.blk) begin
                    mem1[wr_pos.addr[b1_addr_w-1:0]][l*pix_w +: pix_w] <= din;
                end else begin
                    mem0[wr_pos.addr][l*pix_w +: pix_w] <= din;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en && !rd_block) begin
            dout0 <= mem0[rd_addr];
        end
        if (rd_en && rd_block) begin
            dout1 <= mem1[rd_addr[b1_addr_w-1:0]];    // upper bit ignored
        end
    end

    assert property (@(posedge clk) (we && wr_pos.blk) |-> (wr_pos.addr < 2**b1_addr_w))
        else $error("feature_bank: block 1 write address %0d too high", wr_pos.addr);

endmodule

/* feature_buffer/feature_read_mux.sv */
module feature_read_mux (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     rd_en,
    input  logic                     rd_block,
    input  layer_save_pkg::rd_word_t blk0_words,
    input  layer_save_pkg::rd_word_t blk1_words,
    output layer_save_pkg::rd_word_t rd_data,
    output logic                     rd_valid
);
    import layer_save_pkg::*;

    logic blk_q;    // block of the read in flight

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_valid <= 1'b0;
            blk_q    <= 1'b0;
        end else begin
            rd_valid <= rd_en;
            if (rd_en) begin
                blk_q <= rd_block;
            end
        end
    end

    // bank outputs hold until the next read, so select after the edge
    always_comb begin
        for (int i = 0; i < num_ch; i++) begin
            rd_data.ch[i] = blk_q ? blk1_words.ch[i] : blk0_words.ch[i];
        end
    end

endmodule

/* run.sh */
#!/usr/bin/env bash
# build and run the layer saver testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f compile.f \
    --top-module tb_layer_result_saver \
    -Mdir obj_dir -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "^sim passed$" sim.log; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi

/* save_ctrl/raster_counter.sv */
module raster_counter #(
    parameter int width_w   = layer_save_pkg::width_w,
    parameter int b0_addr_w = layer_save_pkg::b0_addr_w
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    clear,
    input  logic                    step,
    input  logic [width_w-1:0]      width,
    output layer_save_pkg::wr_pos_t wr_pos,
    output logic                    last_pix
);
    import layer_save_pkg::*;

    logic [width_w-1:0]   col;
    logic [width_w-1:0]   row;
    logic [lanes-1:0]     lane_oh;
    logic                 blk;
    logic [b0_addr_w-1:0] base;
    logic [b0_addr_w-1:0] width_ext;
    logic [b0_addr_w-1:0] mirror;
    logic                 col_end;
    logic                 row_end;

    assign col_end   = (col == width - width_w'(1));
    assign row_end   = (row == width - width_w'(1));
    assign last_pix  = col_end && row_end;
    assign width_ext = b0_addr_w'(width);
    assign mirror    = width_ext - b0_addr_w'(col) - b0_addr_w'(1);   // rows come right to left

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            col     <= '0;
            row     <= '0;
            lane_oh <= lanes'(1);
            blk     <= 1'b0;
            base    <= '0;
        end else if (clear) begin
            col     <= '0;
            row     <= '0;
            lane_oh <= lanes'(1);
            blk     <= 1'b0;
            base    <= '0;
        end else if (step) begin
            col <= col_end ? '0 : col + width_w'(1);
            if (col_end) begin
                row     <= row_end ? '0 : row + width_w'(1);
                lane_oh <= lane_oh[lanes-1] ? lanes'(1) : lane_oh << 1;
                if (lane_oh[lanes-1]) begin
                    blk <= !blk;
                    // wrapping back to block 0, move to the next strip
                    if (blk) begin
                        base <= base + width_ext;
                    end
                end
            end
        end
    end

    assign wr_pos.blk     = blk;
    assign wr_pos.addr    = base + mirror;
    assign wr_pos.lane_en = lane_oh;

    assert property (@(posedge clk) disable iff (!rst_n)
        step |-> (width >= width_w'(min_width)) && (width <= width_w'(max_width)))
        else $error("raster_counter: width %0d out of range", width);

    assert property (@(posedge clk) disable iff (!rst_n) $onehot(lane_oh))
        else $error("raster_counter: lane enable not one-hot");

endmodule

/* save_ctrl/save_fsm.sv */
module save_fsm (
    input  logic clk,
    input  logic rst_n,
    input  logic start,
    input  logic pix_mark,
    input  logic last_pix,
    output logic clear,
    output logic saving,
    output logic rd_ok,
    output logic save_end,
    output logic busy
);
    import layer_save_pkg::*;

    save_state_e state;
    save_state_e state_nxt;
    logic        fin;

    // a pixel arriving together with start is dropped
    assign clear  = start;
    assign saving = (state == st_saving) && !start;
    assign fin    = saving && pix_mark && last_pix;
    assign busy   = (state == st_saving);
    assign rd_ok  = (state == st_done);

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle, st_done: begin
                if (start) begin
                    state_nxt = st_saving;
                end
            end
            st_saving: begin
                if (start) begin
                    state_nxt = st_saving;      // restart the layer
                end else if (fin) begin
                    state_nxt = st_done;
                end
            end
            default: begin
                state_nxt = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= st_idle;
            save_end <= 1'b0;
        end else begin
            state    <= state_nxt;
            save_end <= fin;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) save_end |=> !save_end)
        else $error("save_fsm: save_end held for two cycles");

endmodule

/* source/layer_result_saver.sv */
module layer_result_saver #(
    parameter int pix_w     = layer_save_pkg::pix_w,
    parameter int width_w   = layer_save_pkg::width_w,
    parameter int b0_addr_w = layer_save_pkg::b0_addr_w,
    parameter int b1_addr_w = layer_save_pkg::b1_addr_w
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              start,
    input  logic [width_w-1:0]                width,
    input  layer_save_pkg::pix_group_t        pix,
    input  logic [layer_save_pkg::num_ch-1:0] pix_valid,
    input  logic                              rd_en,
    input  logic                              rd_block,
    input  logic [b0_addr_w-1:0]              rd_addr,
    output logic                              save_end,
    output logic                              busy,
    output layer_save_pkg::rd_word_t          rd_data,
    output logic                              rd_valid
);
    import layer_save_pkg::*;

    logic     clear;
    logic     saving;
    logic     rd_ok;
    logic     last_pix;
    logic     rd_stb;
    wr_pos_t  wr_pos;
    rd_word_t blk0_words;
    rd_word_t blk1_words;

    assign rd_stb = rd_ok && rd_en;     // reads only once the layer is stored

    save_fsm u_save_fsm (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .pix_mark (pix_valid[0]),
        .last_pix (last_pix),
        .clear    (clear),
        .saving   (saving),
        .rd_ok    (rd_ok),
        .save_end (save_end),
        .busy     (busy)
    );

    raster_counter #(
        .width_w   (width_w),
        .b0_addr_w (b0_addr_w)
    ) u_raster_counter (
        .clk      (clk),
        .rst_n    (rst_n),
        .clear    (clear),
        .step     (pix_valid[0] && saving),
        .width    (width),
        .wr_pos   (wr_pos),
        .last_pix (last_pix)
    );

    for (genvar i = 0; i < num_ch; i++) begin : g_bank
        feature_bank #(
            .pix_w     (pix_w),
            .lanes     (lanes),
            .b0_addr_w (b0_addr_w),
            .b1_addr_w (b1_addr_w)
        ) u_feature_bank (
            .clk      (clk),
            .we       (pix_valid[i] && saving),   // channel mask
            .wr_pos   (wr_pos),
            .din      (pix.ch[i]),
            .rd_en    (rd_stb),
            .rd_block (rd_block),
            .rd_addr  (rd_addr),
            .dout0    (blk0_words.ch[i]),
            .dout1    (blk1_words.ch[i])
        );
    end

    feature_read_mux u_feature_read_mux (
        .clk        (clk),
        .rst_n      (rst_n),
        .rd_en      (rd_stb),
        .rd_block   (rd_block),
        .blk0_words (blk0_words),
        .blk1_words (blk1_words),
        .rd_data    (rd_data),
        .rd_valid   (rd_valid)
    );

endmodule

/* tests/tb_layer_result_saver.sv */
module tb_layer_result_saver;
    timeunit 1ns;
    timeprecision 1ps;
    import layer_save_pkg::*;

    localparam int timeout_cycles = 2000;
    localparam int num_tests      = 7;
    localparam int b0_words       = 2**b0_addr_w;
    localparam int b1_words       = 2**b1_addr_w;

    // with a mask bit low that channel is written only where r + c is even
    typedef struct packed {
        logic [3:0] width;
        logic [3:0] mask;
        logic [7:0] seed_off;
        logic       restart;
    } stim_row_t;

    stim_row_t stim [num_tests] = '{
        '{4'd2,  4'hf, 8'h11, 1'b0},
        '{4'd5,  4'hf, 8'h22, 1'b0},
        '{4'd10, 4'hf, 8'h33, 1'b0},
        '{4'd12, 4'hf, 8'h44, 1'b0},
        '{4'd12, 4'h5, 8'h55, 1'b0},    // ch1, ch3 keep older data on odd pixels
        '{4'd7,  4'hf, 8'h66, 1'b1},
        '{4'd10, 4'hb, 8'h77, 1'b1}
    };

    logic                 clk = 1'b0;
    logic                 rst_n;
    logic                 start;
    logic [width_w-1:0]   width;
    pix_group_t           pix;
    logic [num_ch-1:0]    pix_valid;
    logic                 rd_en;
    logic                 rd_block;
    logic [b0_addr_w-1:0] rd_addr;
    logic                 save_end;
    logic                 busy;
    rd_word_t             rd_data;
    logic                 rd_valid;

    logic [pix_w-1:0] model_val [num_ch][2][b0_words][lanes];
    bit               known     [num_ch][2][b0_words][lanes];
    int               errors    = 0;
    int               end_count = 0;
    bit               abort     = 1'b0;

    layer_result_saver #(
        .pix_w     (pix_w),
        .width_w   (width_w),
        .b0_addr_w (b0_addr_w),
        .b1_addr_w (b1_addr_w)
    ) u_layer_result_saver (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .width     (width),
        .pix       (pix),
        .pix_valid (pix_valid),
        .rd_en     (rd_en),
        .rd_block  (rd_block),
        .rd_addr   (rd_addr),
        .save_end  (save_end),
        .busy      (busy),
        .rd_data   (rd_data),
        .rd_valid  (rd_valid)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        if (save_end) begin
            end_count <= end_count + 1;
        end
    end

    task automatic advance();
        @(posedge clk);
        #2;
    endtask

    task automatic drive_pixel(input int w, input int r, input int c, input stim_row_t s);
        int blk;
        int lane;
        int addr;
        blk  = (r / lanes) % 2;
        lane = r % lanes;
        addr = w - 1 - c;                               // right to left
        if (blk == 0) begin
            addr = addr + w * (r / (2 * lanes));        // next strip of block 0
        end
        for (int i = 0; i < num_ch; i++) begin
            pix.ch[i]    = pix_t'($urandom() + s.seed_off);
            pix_valid[i] = (i == 0) || s.mask[i] || ((r + c) % 2 == 0);
            if (pix_valid[i]) begin
                model_val[i][blk][addr][lane] = pix.ch[i];
                known[i][blk][addr][lane]     = 1'b1;
            end
        end
    endtask

    task automatic feed_pixels(input stim_row_t s, input int count);
        int w;
        w = int'(s.width);
        for (int k = 0; k < count; k++) begin
            if ($urandom() % 4 == 0) begin
                pix_valid = '0;     // idle bubble
                advance();
            end
            drive_pixel(w, k / w, k % w, s);
            advance();
        end
        pix_valid = '0;
    endtask

    task automatic compare_word(input int blk, input int addr);
        logic [pix_w-1:0] got;
        for (int i = 0; i < num_ch; i++) begin
            for (int l = 0; l < lanes; l++) begin
                got = rd_data.ch[i][l*pix_w +: pix_w];
                if (known[i][blk][addr][l] && got !== model_val[i][blk][addr][l]) begin
                    $display("Error at %0t: ch %0d blk %0d addr %0d lane %0d got %h, expected %h",
                             $time, i, blk, addr, l, got, model_val[i][blk][addr][l]);
                    errors++;
                end
            end
        end
    endtask

    // all words of both blocks back to back
    task automatic read_sweep();
        int blk;
        int addr;
        for (int k = 0; k < b0_words + b1_words; k++) begin
            blk      = (k >= b0_words) ? 1 : 0;
            addr     = (k >= b0_words) ? k - b0_words : k;
            rd_en    = 1'b1;
            rd_block = blk[0];
            rd_addr  = b0_addr_w'(addr);
            advance();
            if (rd_valid !== 1'b1) begin
                $display("Error at %0t: no rd_valid for block %0d addr %0d", $time, blk, addr);
                errors++;
            end else begin
                compare_word(blk, addr);
            end
        end
        rd_en = 1'b0;
        advance();
        if (rd_valid !== 1'b0) begin
            $display("Error at %0t: rd_valid still high after the last read", $time);
            errors++;
        end
    endtask

    task automatic run_test(input int t);
        stim_row_t s;
        int        first_err;
        int        first_end;
        int        n;
        s         = stim[t];
        first_err = errors;
        first_end = end_count;
        width     = s.width;
        start     = 1'b1;
        advance();
        start = 1'b0;
        if (busy !== 1'b1) begin
            $display("Error at %0t: busy low after start", $time);
            errors++;
        end
        if (s.restart) begin
            feed_pixels(s, int'(s.width) + 2);
            start = 1'b1;   // restart in mid-layer
            advance();
            start = 1'b0;
        end
        feed_pixels(s, int'(s.width) * int'(s.width));
        n = 0;
        while (save_end !== 1'b1 && n < timeout_cycles) begin
            advance();
            n++;
        end
        if (save_end !== 1'b1) begin
            $display("timeout: save_end never came in test %0d", t + 2);
            abort = 1'b1;
            return;
        end
        if (n != 0 || busy !== 1'b0) begin
            $display("Error at %0t: save_end %0d cycles late, busy %b", $time, n, busy);
            errors++;
        end
        // pixels offered in done are not stored
        pix       = pix_group_t'($urandom());
        pix_valid = '1;
        repeat (2) advance();
        pix_valid = '0;
        repeat (2) advance();
        if (end_count - first_end != 1) begin
            $display("Error at %0t: save_end pulsed %0d times", $time, end_count - first_end);
            errors++;
        end
        read_sweep();
        if (errors == first_err) begin
            $display("test %0d width %0d: passed", t + 2, s.width);
        end else begin
            $display("test %0d width %0d: failed", t + 2, s.width);
        end
    endtask

    initial begin
        int passed;
        int run;
        int first_err;
        void'($urandom(55304));
        rst_n     = 1'b0;
        start     = 1'b0;
        width     = 4'd2;
        pix       = '0;
        pix_valid = '0;
        rd_en     = 1'b0;
        rd_block  = 1'b0;
        rd_addr   = '0;
        passed    = 0;
        run       = 1;
        repeat (4) @(posedge clk);
        #2;
        rst_n = 1'b1;
        if (save_end !== 1'b0 || busy !== 1'b0 || rd_valid !== 1'b0) begin
            $display("Error at %0t: outputs not idle after reset", $time);
            errors++;
        end
        rd_en = 1'b1;   // no data while idle
        repeat (3) begin
            advance();
            if (rd_valid !== 1'b0) begin
                $display("Error at %0t: rd_valid high while idle", $time);
                errors++;
            end
        end
        rd_en = 1'b0;
        if (errors == 0) begin
            passed++;
            $display("test 1 reset and idle read: passed");
        end else begin
            $display("test 1 reset and idle read: failed");
        end
        for (int t = 0; t < num_tests && !abort; t++) begin
            run++;
            first_err = errors;
            run_test(t);
            if (!abort && errors == first_err) begin
                passed++;
            end
        end
        $display("%0d tests run, %0d passed, %0d errors", run, passed, errors);
        if (errors == 0 && !abort) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule
